// File: Makefile
# Verilator simulation of the memory stage testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# The run passes only if the log holds the pass line.
sim:
	rm -f $(LOG)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
+incdir+src
src/mem_stage_pkg.sv
src/lsu_access.sv
src/csr_access.sv
src/mem_result_merge.sv
src/mem_stage.sv
testbench/tb_data_mem.sv
testbench/tb_mem_stage.sv

// File: src/csr_access.sv
// The CSR file must answer csr_rdata, csr_exists and csr_rdonly combinationally from csr_addr.
`timescale 1ns/100ps
`include "mem_stage_settings.svh"

module csr_access (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue,
    input  mem_stage_pkg::insn_t d_insn,
    input  logic [`XLEN-1:0]     d_rs1_val,
    input  logic [`XLEN-1:0]     csr_rdata,
    input  logic                 csr_exists,
    input  logic                 csr_rdonly,
    output logic [11:0]          csr_addr,
    output logic [`XLEN-1:0]     csr_wdata,
    output logic                 csr_we,
    output logic                 csr_active,
    output logic [`XLEN-1:0]     csr_result,
    output logic                 csr_trap
);
    logic             is_csr;
    logic             wants_write;
    logic             illegal;
    logic [`XLEN-1:0] mask;

    // funct3 of zero is ECALL, EBREAK and friends, not a CSR access.
    assign is_csr = d_insn.csr.opcode == `OP_SYSTEM
        && d_insn.csr.csr_op != mem_stage_pkg::CSR_NONE;

    assign mask = d_insn.csr.imm_flag ? {{(`XLEN-5){1'b0}}, d_insn.csr.rs1_imm} : d_rs1_val;

    // Set and clear with a zero rs1 field only read.
    assign wants_write = d_insn.csr.csr_op == mem_stage_pkg::CSR_WRITE
        || d_insn.csr.rs1_imm != 5'd0;
    assign illegal = !csr_exists || (wants_write && csr_rdonly);

    always_comb begin
        case (d_insn.csr.csr_op)
            mem_stage_pkg::CSR_WRITE: csr_wdata = mask;
            mem_stage_pkg::CSR_SET:   csr_wdata = csr_rdata | mask;
            mem_stage_pkg::CSR_CLEAR: csr_wdata = csr_rdata & ~mask;
            default:                  csr_wdata = csr_rdata;
        endcase
    end

    assign csr_addr = d_insn.csr.csr_addr;
    assign csr_we   = issue && is_csr && wants_write && !illegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_active <= 1'b0;
            csr_trap   <= 1'b0;
        end else begin
            csr_active <= issue && is_csr;
            csr_trap   <= issue && is_csr && illegal;
        end
    end

    // Old value, returned to rd.
    always_ff @(posedge clk) begin
        if (issue && is_csr) begin
            csr_result <= csr_rdata;
        end
    end

    a_we_issue: assert property (@(posedge clk) disable iff (rst)
        csr_we |-> issue ##1 (csr_active && !csr_trap))
        else $error("csr_access: CSR write without a legal issued access");

endmodule

// File: src/lsu_access.sv
// One outstanding request; the bus must hold dbus_rdata valid in the cycle dbus_ready is high.
`timescale 1ns/100ps
`include "mem_stage_settings.svh"

module lsu_access (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue,
    input  mem_stage_pkg::insn_t d_insn,
    input  logic [`XLEN-1:0]     d_rs1_val,
    input  logic [`XLEN-1:0]     d_rs2_val,
    input  logic                 dbus_ready,
    input  logic [`XLEN-1:0]     dbus_rdata,
    output logic [`XLEN-1:2]     dbus_addr,
    output logic                 dbus_re,
    output logic [3:0]           dbus_we,
    output logic [`XLEN-1:0]     dbus_wdata,
    output logic                 lsu_active,
    output logic                 lsu_busy,
    output logic [`XLEN-1:0]     lsu_rdata,
    output logic                 lsu_trap,
    output logic [3:0]           lsu_cause
);
    logic             is_load;
    logic             is_store;
    logic             is_mem;
    logic             misaligned;
    logic [3:0]       lane_en;
    logic [`XLEN-1:0] lane_data;
    logic [1:0]       size_q;
    logic             unsigned_q;
    logic [1:0]       offset_q;
    logic [7:0]       byte_sel;
    logic [15:0]      half_sel;

    assign is_load  = d_insn.mem.opcode == `OP_LOAD;
    assign is_store = d_insn.mem.opcode == `OP_STORE;
    assign is_mem   = issue && (is_load || is_store);

    // Alignment, byte lanes and replicated store data.
    always_comb begin
        case (d_insn.mem.size)
            `SIZE_BYTE: begin
                misaligned = 1'b0;
                lane_en    = 4'b0001 << d_rs1_val[1:0];
                lane_data  = {4{d_rs2_val[7:0]}};
            end
            `SIZE_HALF: begin
                misaligned = d_rs1_val[0];
                lane_en    = d_rs1_val[1] ? 4'b1100 : 4'b0011;
                lane_data  = {2{d_rs2_val[15:0]}};
            end
            `SIZE_WORD: begin
                misaligned = d_rs1_val[1:0] != 2'b00;
                lane_en    = 4'b1111;
                lane_data  = d_rs2_val;
            end
            default: begin
                // Size code 3 has no RV32 access, so it never reaches the bus.
                misaligned = 1'b1;
                lane_en    = 4'b0000;
                lane_data  = d_rs2_val;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dbus_re  <= 1'b0;
            dbus_we  <= 4'b0000;
            lsu_trap <= 1'b0;
        end else begin
            lsu_trap <= is_mem && misaligned;
            if (is_mem && !misaligned) begin
                dbus_re <= is_load;
                dbus_we <= is_store ? lane_en : 4'b0000;
            end else if (dbus_ready) begin
                dbus_re <= 1'b0;
                dbus_we <= 4'b0000;
            end
        end
    end

    // Request payload and lane bookkeeping.
    always_ff @(posedge clk) begin
        if (is_mem) begin
            dbus_addr  <= d_rs1_val[`XLEN-1:2];
            dbus_wdata <= lane_data;
            size_q     <= d_insn.mem.size;
            unsigned_q <= d_insn.mem.is_unsigned;
            offset_q   <= d_rs1_val[1:0];
            lsu_cause  <= is_store ? `CAUSE_STORE_ALIGN : `CAUSE_LOAD_ALIGN;
        end
    end

    assign lsu_active = dbus_re || (dbus_we != 4'b0000);
    assign lsu_busy   = lsu_active && !dbus_ready;

    // Pick the addressed lane and extend it.
    always_comb begin
        byte_sel = dbus_rdata[{offset_q, 3'b000} +: 8];
        half_sel = offset_q[1] ? dbus_rdata[31:16] : dbus_rdata[15:0];
        case (size_q)
            `SIZE_BYTE: lsu_rdata = {{(`XLEN-8){!unsigned_q && byte_sel[7]}}, byte_sel};
            `SIZE_HALF: lsu_rdata = {{(`XLEN-16){!unsigned_q && half_sel[15]}}, half_sel};
            default:    lsu_rdata = dbus_rdata;
        endcase
    end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        lsu_busy |=> $stable(dbus_addr) && $stable(dbus_re) && $stable(dbus_we)
            && $stable(dbus_wdata))
        else $error("lsu_access: request changed before dbus_ready");

    a_re_we_excl: assert property (@(posedge clk) disable iff (rst)
        !(dbus_re && dbus_we != 4'b0000))
        else $error("lsu_access: read and write requested together");

endmodule

// File: src/mem_result_merge.sv
// No downstream back-pressure: a result is taken in the cycle it is presented.
`timescale 1ns/100ps
`include "mem_stage_settings.svh"

module mem_result_merge (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 d_valid,
    input  logic [`XLEN-1:1]     d_pc,
    input  mem_stage_pkg::insn_t d_insn,
    input  logic                 d_use_rd,
    input  logic [`XLEN-1:0]     d_rs1_val,
    input  logic                 d_trap,
    input  logic [3:0]           d_cause,
    input  logic                 lsu_active,
    input  logic                 lsu_busy,
    input  logic [`XLEN-1:0]     lsu_rdata,
    input  logic                 lsu_trap,
    input  logic [3:0]           lsu_cause,
    input  logic                 csr_active,
    input  logic [`XLEN-1:0]     csr_result,
    input  logic                 csr_trap,
    output logic                 issue,
    output logic                 stall_req,
    output logic                 q_valid,
    output logic [`XLEN-1:1]     q_pc,
    output logic [31:0]          q_insn,
    output logic                 q_use_rd,
    output logic [`XLEN-1:0]     q_rd_val,
    output logic                 q_trap,
    output logic [3:0]           q_cause
);
    logic                 accept;
    logic                 held;
    mem_stage_pkg::insn_t held_insn;
    logic [`XLEN-1:0]     held_rs1_val;
    logic                 held_trap;
    logic [3:0]           held_cause;

    assign stall_req = lsu_busy;
    assign accept    = d_valid && !stall_req;
    // Trapped instructions never touch the bus or the CSR file.
    assign issue     = accept && !d_trap;

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else if (accept) begin
            held <= 1'b1;
        end else if (q_valid) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            q_pc         <= d_pc;
            held_insn    <= d_insn;
            q_use_rd     <= d_use_rd;
            held_rs1_val <= d_rs1_val;
            held_trap    <= d_trap;
            held_cause   <= d_cause;
        end
    end

    assign q_valid = held && !lsu_busy;
    assign q_insn  = held_insn;
    assign q_trap  = held && (held_trap || lsu_trap || csr_trap);

    // Earlier traps win.
    always_comb begin
        if (held_trap) begin
            q_cause = held_cause;
        end else if (lsu_trap) begin
            q_cause = lsu_cause;
        end else if (csr_trap) begin
            q_cause = `CAUSE_ILLEGAL;
        end else begin
            q_cause = 4'd0;
        end
    end

    assign q_rd_val = csr_active ? csr_result : (lsu_active ? lsu_rdata : held_rs1_val);

    a_hold_while_busy: assert property (@(posedge clk) disable iff (rst)
        (held && lsu_busy) |-> !q_valid ##1 held)
        else $error("mem_result_merge: item lost or emitted during a bus access");

endmodule

// File: src/mem_stage.sv
// Memory stage without the A extension or fences; stall_req is the only flow control.
`timescale 1ns/100ps
`include "mem_stage_settings.svh"

module mem_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             d_valid,
    input  logic [`XLEN-1:1] d_pc,
    input  logic [31:0]      d_insn,
    input  logic             d_use_rd,
    input  logic [`XLEN-1:0] d_rs1_val,
    input  logic [`XLEN-1:0] d_rs2_val,
    input  logic             d_trap,
    input  logic [3:0]       d_cause,
    output logic             q_valid,
    output logic [`XLEN-1:1] q_pc,
    output logic [31:0]      q_insn,
    output logic             q_use_rd,
    output logic [`XLEN-1:0] q_rd_val,
    output logic             q_trap,
    output logic [3:0]       q_cause,
    output logic             stall_req,
    output logic [`XLEN-1:2] dbus_addr,
    output logic             dbus_re,
    output logic [3:0]       dbus_we,
    output logic [`XLEN-1:0] dbus_wdata,
    input  logic             dbus_ready,
    input  logic [`XLEN-1:0] dbus_rdata,
    output logic [11:0]      csr_addr,
    output logic [`XLEN-1:0] csr_wdata,
    output logic             csr_we,
    input  logic [`XLEN-1:0] csr_rdata,
    input  logic             csr_exists,
    input  logic             csr_rdonly
);
    logic             issue;
    logic             lsu_active;
    logic             lsu_busy;
    logic [`XLEN-1:0] lsu_rdata;
    logic             lsu_trap;
    logic [3:0]       lsu_cause;
    logic             csr_active;
    logic [`XLEN-1:0] csr_result;
    logic             csr_trap;

    lsu_access lsu0 (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .d_insn     (d_insn),
        .d_rs1_val  (d_rs1_val),
        .d_rs2_val  (d_rs2_val),
        .dbus_ready (dbus_ready),
        .dbus_rdata (dbus_rdata),
        .dbus_addr  (dbus_addr),
        .dbus_re    (dbus_re),
        .dbus_we    (dbus_we),
        .dbus_wdata (dbus_wdata),
        .lsu_active (lsu_active),
        .lsu_busy   (lsu_busy),
        .lsu_rdata  (lsu_rdata),
        .lsu_trap   (lsu_trap),
        .lsu_cause  (lsu_cause)
    );

    csr_access csr0 (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .d_insn     (d_insn),
        .d_rs1_val  (d_rs1_val),
        .csr_rdata  (csr_rdata),
        .csr_exists (csr_exists),
        .csr_rdonly (csr_rdonly),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .csr_we     (csr_we),
        .csr_active (csr_active),
        .csr_result (csr_result),
        .csr_trap   (csr_trap)
    );

    mem_result_merge merge0 (
        .clk        (clk),
        .rst        (rst),
        .d_valid    (d_valid),
        .d_pc       (d_pc),
        .d_insn     (d_insn),
        .d_use_rd   (d_use_rd),
        .d_rs1_val  (d_rs1_val),
        .d_trap     (d_trap),
        .d_cause    (d_cause),
        .lsu_active (lsu_active),
        .lsu_busy   (lsu_busy),
        .lsu_rdata  (lsu_rdata),
        .lsu_trap   (lsu_trap),
        .lsu_cause  (lsu_cause),
        .csr_active (csr_active),
        .csr_result (csr_result),
        .csr_trap   (csr_trap),
        .issue      (issue),
        .stall_req  (stall_req),
        .q_valid    (q_valid),
        .q_pc       (q_pc),
        .q_insn     (q_insn),
        .q_use_rd   (q_use_rd),
        .q_rd_val   (q_rd_val),
        .q_trap     (q_trap),
        .q_cause    (q_cause)
    );

endmodule

// File: src/mem_stage_pkg.sv
// Both views assume the standard 32-bit RISC-V I-type layout; compressed encodings are not decoded.
package mem_stage_pkg;

    // Load and store view of the instruction word.
    typedef struct packed {
        logic [16:0] upper;
        logic        is_unsigned;
        logic [1:0]  size;
        logic [4:0]  rd;
        logic [4:0]  opcode;
        logic [1:0]  quadrant;
    } mem_view_t;

    // CSR instruction view of the same word.
    typedef struct packed {
        logic [11:0] csr_addr;
        logic [4:0]  rs1_imm;
        logic        imm_flag;
        logic [1:0]  csr_op;
        logic [4:0]  rd;
        logic [4:0]  opcode;
        logic [1:0]  quadrant;
    } csr_view_t;

    // CSR operation codes, funct3 bits 1:0.
    typedef enum logic [1:0] {
        CSR_NONE  = 2'b00,
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_t;

    // One instruction word, decoded as memory or CSR access.
    typedef union packed {
        mem_view_t mem;
        csr_view_t csr;
    } insn_t;

endpackage

// File: src/mem_stage_settings.svh
// RV32 only; the opcode values are instruction bits 6:2 and the size codes are funct3 bits 1:0.
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// Data and address width.
`define XLEN 32

// Major opcodes, instruction bits 6:2.
`define OP_LOAD   5'b00000
`define OP_STORE  5'b01000
`define OP_SYSTEM 5'b11100

// Trap cause codes.
`define CAUSE_ILLEGAL     4'd2
`define CAUSE_LOAD_ALIGN  4'd4
`define CAUSE_STORE_ALIGN 4'd6

// Access sizes, funct3 bits 1:0.
`define SIZE_BYTE 2'b00
`define SIZE_HALF 2'b01
`define SIZE_WORD 2'b10

`endif

// File: testbench/tb_data_mem.sv
// Only byte addresses below 256 are modeled; higher address bits are ignored and alias.
`timescale 1ns/100ps

module tb_data_mem #(
    parameter logic [31:0] seed_init = 32'h0dded185
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:2] dbus_addr,
    input  logic        dbus_re,
    input  logic [3:0]  dbus_we,
    input  logic [31:0] dbus_wdata,
    output logic        dbus_ready,
    output logic [31:0] dbus_rdata
);
    logic [7:0]  mem_bytes [256];
    logic [31:0] rnd;
    logic [1:0]  delay_left;
    int          seed;

    // Fill value depends on the full byte address.
    initial begin
        seed = seed_init;
        for (int i = 0; i < 256; i++) begin
            mem_bytes[i[7:0]] = i[7:0] ^ 8'h5a;
        end
    end

    // Little-endian word at the requested address.
    assign dbus_rdata = {mem_bytes[{dbus_addr[7:2], 2'd3}], mem_bytes[{dbus_addr[7:2], 2'd2}],
                         mem_bytes[{dbus_addr[7:2], 2'd1}], mem_bytes[{dbus_addr[7:2], 2'd0}]};

    // Ready comes zero to three cycles after the request is first seen.
    always @(posedge clk) begin
        if (rst) begin
            dbus_ready <= 1'b0;
            delay_left <= 2'd0;
        end else if (dbus_ready) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dbus_we[lane]) begin
                    mem_bytes[{dbus_addr[7:2], lane[1:0]}] <= dbus_wdata[lane*8 +: 8];
                end
            end
            rnd = $random(seed);
            delay_left <= rnd[1:0];
            dbus_ready <= 1'b0;
        end else if (dbus_re || dbus_we != 4'b0000) begin
            if (delay_left == 2'd0) begin
                dbus_ready <= 1'b1;
            end else begin
                delay_left <= delay_left - 2'd1;
            end
        end
    end

endmodule

// File: testbench/tb_mem_stage.sv
// Addresses stay below 256 bytes and only three CSRs exist; results must leave in order.
`timescale 1ns/100ps
`include "mem_stage_settings.svh"

module tb_mem_stage;
    typedef struct packed {
        logic [31:1] pc;
        logic [31:0] insn;
        logic        use_rd;
        logic        trap;
        logic [3:0]  cause;
        logic        check_val;
        logic [31:0] val;
    } result_t;

    localparam int num_insns = 600;

    logic             clk;
    logic             rst;
    logic             d_valid;
    logic [`XLEN-1:1] d_pc;
    logic [31:0]      d_insn;
    logic             d_use_rd;
    logic [`XLEN-1:0] d_rs1_val;
    logic [`XLEN-1:0] d_rs2_val;
    logic             d_trap;
    logic [3:0]       d_cause;
    logic             q_valid;
    logic [`XLEN-1:1] q_pc;
    logic [31:0]      q_insn;
    logic             q_use_rd;
    logic [`XLEN-1:0] q_rd_val;
    logic             q_trap;
    logic [3:0]       q_cause;
    logic             stall_req;
    logic [`XLEN-1:2] dbus_addr;
    logic             dbus_re;
    logic [3:0]       dbus_we;
    logic [`XLEN-1:0] dbus_wdata;
    logic             dbus_ready;
    logic [`XLEN-1:0] dbus_rdata;
    logic [11:0]      csr_addr;
    logic [`XLEN-1:0] csr_wdata;
    logic             csr_we;
    logic [`XLEN-1:0] csr_rdata;
    logic             csr_exists;
    logic             csr_rdonly;

    logic [31:0] csr_regs [3];
    logic [31:0] csr_model [3];
    logic [7:0]  mem_model [256];
    result_t     exp_q [$];
    int          seed;
    int          errors;
    int          timeouts;
    int          csr_writes;
    int          exp_csr_writes;
    int          bus_done;
    int          exp_bus_done;
    bit          timed_out;

    mem_stage dut0 (.*);

    tb_data_mem #(.seed_init(32'h0dded185)) mem0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Model CSR file: mscratch, mtvec and the read-only mhartid.
    function automatic logic [1:0] csr_index(input logic [11:0] addr);
        case (addr)
            12'h340: return 2'd0;
            12'h305: return 2'd1;
            12'hf14: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    assign csr_exists = csr_index(csr_addr) != 2'd3;
    assign csr_rdonly = csr_index(csr_addr) == 2'd2;
    assign csr_rdata  = csr_exists ? csr_regs[csr_index(csr_addr)] : 32'd0;

    always @(posedge clk) begin
        if (csr_we && csr_exists) begin
            csr_regs[csr_index(csr_addr)] <= csr_wdata;
        end
    end

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // Read-only mhartid is picked twice as often.
    function automatic logic [11:0] pick_csr(input logic [2:0] sel);
        case (sel)
            3'd0:       return 12'h340;
            3'd1:       return 12'h305;
            3'd2, 3'd3: return 12'hf14;
            3'd4:       return 12'h341;
            3'd5:       return 12'h7c0;
            default:    return 12'hc00;
        endcase
    endfunction

    function automatic logic [31:0] load_value(input logic [7:0] addr, input logic [1:0] size,
                                               input logic uns);
        logic [31:0] word;
        word = {mem_model[addr + 8'd3], mem_model[addr + 8'd2], mem_model[addr + 8'd1],
                mem_model[addr]};
        case (size)
            `SIZE_BYTE: return uns ? {24'd0, word[7:0]} : {{24{word[7]}}, word[7:0]};
            `SIZE_HALF: return uns ? {16'd0, word[15:0]} : {{16{word[15]}}, word[15:0]};
            default:    return word;
        endcase
    endfunction

    task automatic write_model_bytes(input logic [7:0] addr, input logic [1:0] size,
                                     input logic [31:0] data);
        int n;
        n = (size == `SIZE_BYTE) ? 1 : ((size == `SIZE_HALF) ? 2 : 4);
        for (int i = 0; i < n; i++) begin
            mem_model[addr + i[7:0]] = data[i*8 +: 8];
        end
    endtask

    // Picks one instruction, predicts its result, drives it and waits until it is taken.
    task automatic send_random_insn();
        logic [31:0] r;
        logic [31:0] rb;
        logic [31:0] pcr;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] insn;
        logic [31:0] mask;
        logic [7:0]  addr;
        logic [1:0]  size;
        logic [1:0]  op;
        logic [1:0]  idx;
        logic [4:0]  field;
        logic [11:0] csr;
        logic        uns;
        logic        bad;
        logic        will_write;
        logic        trap_in;
        logic        accepted;
        int          cycles;
        result_t     want;

        r   = next_random();
        rb  = next_random();
        pcr = next_random();
        rs1 = next_random();
        rs2 = next_random();
        trap_in = r[7:4] == 4'd0;
        size = (r[10:9] == 2'b11) ? `SIZE_WORD : r[10:9];
        uns  = r[11] && size != `SIZE_WORD;
        bad  = r[14:12] == 3'd0 && size != `SIZE_BYTE;
        addr = rs1[7:0];
        if (size == `SIZE_HALF) begin
            addr[0] = bad;
        end else if (size == `SIZE_WORD) begin
            addr[1:0] = bad ? ((r[16:15] == 2'b00) ? 2'b10 : r[16:15]) : 2'b00;
        end
        want.pc        = pcr[31:1];
        want.use_rd    = r[8];
        want.trap      = 1'b0;
        want.cause     = 4'd0;
        want.check_val = 1'b1;
        want.val       = rs1;
        case (r[2:0])
            3'd0, 3'd1, 3'd2: begin
                insn = {rb[31:15], uns, size, rb[11:7], `OP_LOAD, 2'b11};
                rs1  = {24'd0, addr};
                if (!trap_in && bad) begin
                    want.trap      = 1'b1;
                    want.cause     = `CAUSE_LOAD_ALIGN;
                    want.check_val = 1'b0;
                end else if (!trap_in) begin
                    want.val = load_value(addr, size, uns);
                    exp_bus_done++;
                end
            end
            3'd3, 3'd4: begin
                insn = {rb[31:15], 1'b0, size, rb[11:7], `OP_STORE, 2'b11};
                rs1  = {24'd0, addr};
                want.check_val = 1'b0;
                if (!trap_in && bad) begin
                    want.trap  = 1'b1;
                    want.cause = `CAUSE_STORE_ALIGN;
                end else if (!trap_in) begin
                    write_model_bytes(addr, size, rs2);
                    exp_bus_done++;
                end
            end
            3'd5, 3'd6: begin
                csr   = pick_csr(rb[2:0]);
                field = (rb[4:3] == 2'b00) ? 5'd0 : rb[9:5];
                op    = (rb[11:10] == 2'b00) ? 2'b01 : rb[11:10];
                insn  = {csr, field, rb[12], op, rb[17:13], `OP_SYSTEM, 2'b11};
                idx   = csr_index(csr);
                mask  = rb[12] ? {27'd0, field} : rs1;
                will_write = op == 2'b01 || field != 5'd0;
                if (!trap_in && (idx == 2'd3 || (will_write && idx == 2'd2))) begin
                    want.trap      = 1'b1;
                    want.cause     = `CAUSE_ILLEGAL;
                    want.check_val = 1'b0;
                end else if (!trap_in) begin
                    want.val = csr_model[idx];
                    if (will_write) begin
                        exp_csr_writes++;
                        case (op)
                            2'b01:   csr_model[idx] = mask;
                            2'b10:   csr_model[idx] = csr_model[idx] | mask;
                            default: csr_model[idx] = csr_model[idx] & ~mask;
                        endcase
                    end
                end
            end
            default: begin
                insn = {rb[31:7], 7'b0010011};
            end
        endcase
        if (trap_in) begin
            want.trap      = 1'b1;
            want.cause     = r[20:17];
            want.check_val = 1'b0;
        end
        want.insn = insn;

        d_valid   = 1'b1;
        d_pc      = want.pc;
        d_insn    = insn;
        d_use_rd  = want.use_rd;
        d_rs1_val = rs1;
        d_rs2_val = rs2;
        d_trap    = trap_in;
        d_cause   = r[20:17];
        accepted  = 1'b0;
        cycles    = 0;
        while (!accepted && !timed_out) begin
            @(negedge clk);
            if (!stall_req) begin
                accepted = 1'b1;
                exp_q.push_back(want);
            end else begin
                cycles++;
                if (cycles > 50) begin
                    $display("timeout: instruction at pc %h not accepted in 50 cycles",
                             {want.pc, 1'b0});
                    timeouts++;
                    timed_out = 1'b1;
                end
            end
            @(posedge clk);
            #1;
        end
        d_valid = 1'b0;
    endtask

    task automatic check_result();
        result_t want;
        assert (exp_q.size() != 0) else begin
            $display("error at %0t ns: result with no accepted instruction", $time);
            errors++;
        end
        if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            assert (q_pc == want.pc && q_insn == want.insn && q_use_rd == want.use_rd) else begin
                $display("error at %0t ns: insn %h pc %h out of order, expected insn %h pc %h",
                         $time, q_insn, {q_pc, 1'b0}, want.insn, {want.pc, 1'b0});
                errors++;
            end
            assert (q_trap == want.trap && (!want.trap || q_cause == want.cause)) else begin
                $display("error at %0t ns: insn %h trap %b cause %0d, expected %b cause %0d",
                         $time, q_insn, q_trap, q_cause, want.trap, want.cause);
                errors++;
            end
            assert (!want.check_val || q_rd_val == want.val) else begin
                $display("error at %0t ns: insn %h rd value %h, expected %h",
                         $time, q_insn, q_rd_val, want.val);
                errors++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (csr_we) begin
                csr_writes++;
            end
            if (dbus_ready) begin
                bus_done++;
            end
            if (q_valid) begin
                check_result();
            end
        end
    end

    task automatic check_final_state();
        for (int i = 0; i < 256; i++) begin
            assert (mem0.mem_bytes[i[7:0]] === mem_model[i[7:0]]) else begin
                $display("error at %0t ns: memory byte %h is %h, expected %h", $time, i[7:0],
                         mem0.mem_bytes[i[7:0]], mem_model[i[7:0]]);
                errors++;
            end
        end
        for (int i = 0; i < 3; i++) begin
            assert (csr_regs[i[1:0]] === csr_model[i[1:0]]) else begin
                $display("error at %0t ns: CSR slot %0d is %h, expected %h", $time, i,
                         csr_regs[i[1:0]], csr_model[i[1:0]]);
                errors++;
            end
        end
        assert (bus_done == exp_bus_done && csr_writes == exp_csr_writes) else begin
            $display("error at %0t ns: %0d bus and %0d CSR writes, expected %0d and %0d",
                     $time, bus_done, csr_writes, exp_bus_done, exp_csr_writes);
            errors++;
        end
    endtask

    initial begin
        int cycles;
        seed           = 32'h0dded185;
        errors         = 0;
        timeouts       = 0;
        csr_writes     = 0;
        exp_csr_writes = 0;
        bus_done       = 0;
        exp_bus_done   = 0;
        timed_out      = 1'b0;
        rst            = 1'b1;
        d_valid        = 1'b0;
        d_pc           = '0;
        d_insn         = 32'd0;
        d_use_rd       = 1'b0;
        d_rs1_val      = 32'd0;
        d_rs2_val      = 32'd0;
        d_trap         = 1'b0;
        d_cause        = 4'd0;
        csr_regs[0]    = 32'h1234_5678;
        csr_regs[1]    = 32'h0000_0100;
        csr_regs[2]    = 32'h0000_0003;
        for (int i = 0; i < 3; i++) begin
            csr_model[i[1:0]] = csr_regs[i[1:0]];
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (!q_valid && !dbus_re && dbus_we == 4'b0000 && !csr_we && !stall_req) else begin
            $display("error at %0t ns: stage outputs active during reset", $time);
            errors++;
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        // The model starts from the memory's fill pattern.
        for (int i = 0; i < 256; i++) begin
            mem_model[i[7:0]] = mem0.mem_bytes[i[7:0]];
        end

        for (int n = 0; n < num_insns && !timed_out; n++) begin
            send_random_insn();
            if (next_random() % 4 == 0) begin
                repeat (2) begin
                    @(posedge clk);
                    #1;
                end
            end
        end

        cycles = 0;
        while (exp_q.size() != 0 && !timed_out) begin
            @(posedge clk);
            cycles++;
            if (cycles > 100) begin
                $display("timeout: %0d results never left the stage", exp_q.size());
                timeouts++;
                timed_out = 1'b1;
            end
        end
        // Let the last bus write land.
        repeat (2) @(negedge clk);
        check_final_state();

        $display("errors: %0d wrong values, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
